// File: src/icache_pkg.sv
//////////////////////////////
// Geometry and shared types of the instruction cache
// Referenced by scoped name from every module of the cache
//////////////////////////////

`default_nettype none

package icache_pkg;

   localparam int NB_WAYS = 4;
   localparam int NB_SETS = 16;
   localparam int SET_W   = 4;
   localparam int TAG_W   = 24;
   localparam int LINE_W  = 128;
   localparam int WORD_W  = 32;

   // Last set index swept by a full flush
   localparam logic [SET_W-1:0] FLUSH_LAST = SET_W'(NB_SETS - 1);

   // Fetch address split into cache fields
   typedef struct packed {
      logic [TAG_W-1:0] tag;
      logic [SET_W-1:0] set;
      logic [1:0]       word;      // Word inside the 128-bit line
      logic [1:0]       byte_off;
   } fetch_addr_t;

   typedef struct packed {
      logic             valid;
      logic [TAG_W-1:0] tag;
   } tag_entry_t;

   typedef logic [NB_WAYS-1:0] way_oh_t;   // One-hot way
   typedef logic [LINE_W-1:0]  line_t;
   typedef logic [WORD_W-1:0]  word_t;

   // Write command to the tag arrays
   typedef struct packed {
      logic             we;
      way_oh_t          way_mask;
      logic [SET_W-1:0] set;
      tag_entry_t       entry;
   } tag_cmd_t;

endpackage

`default_nettype wire

// File: src/icache_victim_select.sv
//////////////////////////////
// Way to refill on a miss
// First free way, else a pseudo-random way from an LFSR
//////////////////////////////

`default_nettype none

module icache_victim_select (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire                               choose_i,
   input  wire                               all_valid_i,
   input  wire icache_pkg::way_oh_t          free_way_i,
   output icache_pkg::way_oh_t               victim_way_o
);

   logic [7:0] lfsr_q;
   logic       feedback;

   // Taps for x^8 + x^6 + x^5 + x^4 + 1
   assign feedback = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         lfsr_q <= 8'hA5;   // Any non-zero seed
      end
      else if (choose_i)
      begin
         lfsr_q <= {lfsr_q[6:0], feedback};
      end
   end

   // Low LFSR bits name the way when the set is full
   assign victim_way_o = all_valid_i ? icache_pkg::way_oh_t'(1 << lfsr_q[1:0]) : free_way_i;

endmodule

`default_nettype wire

// File: src/icache_tag_store.sv
//////////////////////////////
// Tag arrays of all ways with valid bits
// Registered read, hit compare and lowest free way
//////////////////////////////

`default_nettype none

module icache_tag_store (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire icache_pkg::tag_cmd_t         tag_cmd_i,
   input  wire                               rd_en_i,
   input  wire [icache_pkg::SET_W-1:0]       rd_set_i,
   input  wire [icache_pkg::TAG_W-1:0]       cmp_tag_i,
   output icache_pkg::way_oh_t               hit_way_o,
   output logic                              all_valid_o,
   output icache_pkg::way_oh_t               free_way_o
);

   icache_pkg::tag_entry_t rd_entry [icache_pkg::NB_WAYS];

   for (genvar w = 0; w < icache_pkg::NB_WAYS; w++)
   begin : g_way
      logic [icache_pkg::NB_SETS-1:0] valid_q;
      logic [icache_pkg::TAG_W-1:0]   tag_mem [icache_pkg::NB_SETS];
      icache_pkg::tag_entry_t         rd_q;
      logic                           wr_en;

      assign wr_en = tag_cmd_i.we & tag_cmd_i.way_mask[w];

      // Valid bits start cleared
      always_ff @(posedge clk or negedge rst_n)
      begin
         if (!rst_n)
         begin
            valid_q <= '0;
         end
         else if (wr_en)
         begin
            valid_q[tag_cmd_i.set] <= tag_cmd_i.entry.valid;
         end
      end

      always_ff @(posedge clk)
      begin
         if (wr_en)
         begin
            tag_mem[tag_cmd_i.set] <= tag_cmd_i.entry.tag;
         end
         if (rd_en_i)
         begin
            rd_q <= '{valid: valid_q[rd_set_i], tag: tag_mem[rd_set_i]};
         end
      end

      assign rd_entry[w] = rd_q;
   end

   //////////////////////////////
   // Compare on the registered entries
   //////////////////////////////
   always_comb
   begin
      hit_way_o   = '0;
      free_way_o  = '0;
      all_valid_o = 1'b1;
      for (int w = icache_pkg::NB_WAYS - 1; w >= 0; w--)
      begin
         hit_way_o[w] = rd_entry[w].valid & (rd_entry[w].tag == cmp_tag_i);
         all_valid_o  = all_valid_o & rd_entry[w].valid;
         if (!rd_entry[w].valid)
         begin
            free_way_o    = '0;   // Lowest invalid way wins
            free_way_o[w] = 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

// File: src/icache_data_store.sv
//////////////////////////////
// Line arrays of all ways
// Picks the hit word, or forwards the refill word
//////////////////////////////

`default_nettype none

module icache_data_store (
   input  wire                               clk,
   input  wire icache_pkg::way_oh_t          wr_way_i,
   input  wire [icache_pkg::SET_W-1:0]       wr_set_i,
   input  wire icache_pkg::line_t            wr_line_i,
   input  wire [icache_pkg::SET_W-1:0]       rd_set_i,
   input  wire icache_pkg::way_oh_t          hit_way_i,
   input  wire [1:0]                         word_sel_i,
   input  wire                               use_refill_i,
   input  wire icache_pkg::line_t            refill_line_i,
   output icache_pkg::word_t                 rdata_o
);

   icache_pkg::line_t way_line [icache_pkg::NB_WAYS];
   icache_pkg::line_t hit_line;
   logic [icache_pkg::LINE_W/icache_pkg::WORD_W-1:0][icache_pkg::WORD_W-1:0] src_words;

   for (genvar w = 0; w < icache_pkg::NB_WAYS; w++)
   begin : g_way
      icache_pkg::line_t line_mem [icache_pkg::NB_SETS];
      icache_pkg::line_t rd_q;

      always_ff @(posedge clk)
      begin
         if (wr_way_i[w])
         begin
            line_mem[wr_set_i] <= wr_line_i;
         end
         rd_q <= line_mem[rd_set_i];
      end

      assign way_line[w] = rd_q & {icache_pkg::LINE_W{hit_way_i[w]}};
   end

   always_comb
   begin
      hit_line = '0;
      for (int w = 0; w < icache_pkg::NB_WAYS; w++)
      begin
         hit_line = hit_line | way_line[w];   // Hit vector is one-hot
      end
   end

   assign src_words = use_refill_i ? refill_line_i : hit_line;
   assign rdata_o   = src_words[word_sel_i];

endmodule

`default_nettype wire

// File: src/icache_ctrl_fsm.sv
//////////////////////////////
// Main control FSM of the instruction cache
// Handles bypass, full and set flush, tag lookup and miss refill
//////////////////////////////

`default_nettype none

module icache_ctrl_fsm (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire                               bypass_i,
   input  wire                               flush_i,
   input  wire                               flush_set_req_i,
   input  wire icache_pkg::fetch_addr_t      flush_set_addr_i,
   output logic                              flush_set_ack_o,
   output logic                              bypassed_o,
   output logic                              flushed_o,
   input  wire                               fetch_req_i,
   input  wire icache_pkg::fetch_addr_t      fetch_addr_i,
   output logic                              fetch_gnt_o,
   output logic                              fetch_rvalid_o,
   input  wire icache_pkg::way_oh_t          hit_way_i,
   input  wire                               all_valid_i,
   input  wire icache_pkg::way_oh_t          victim_way_i,
   output logic                              choose_o,
   output icache_pkg::tag_cmd_t              tag_cmd_o,
   output logic [icache_pkg::SET_W-1:0]      data_rd_set_o,
   output icache_pkg::way_oh_t               data_wr_way_o,
   output logic [1:0]                        word_sel_o,
   output logic                              use_refill_o,
   output logic                              refill_req_o,
   input  wire                               refill_gnt_i,
   output icache_pkg::fetch_addr_t           refill_addr_o,
   input  wire                               refill_rvalid_i
);

   typedef enum logic [3:0] {
      ST_DISABLED,
      ST_BYP_REFILL,
      ST_BYP_WAIT,
      ST_FLUSH_ALL,
      ST_FLUSH_SET,
      ST_SET_ACK,
      ST_IDLE,
      ST_LOOKUP,
      ST_WAIT_GNT,
      ST_WAIT_DONE
   } state_e;

   state_e                          state_q, state_d;
   icache_pkg::fetch_addr_t         fetch_addr_q;
   icache_pkg::way_oh_t             victim_q;
   logic [icache_pkg::SET_W-1:0]    flush_cnt_q, flush_cnt_d;
   logic                            byp_pend_q, byp_pend_d;
   logic                            save_victim;
   logic                            block_fetch;
   logic                            hit;

   // Tag and data arrays are read with the address the core presents
   assign data_rd_set_o = fetch_addr_i.set;
   assign word_sel_o    = fetch_addr_q.word;
   assign refill_addr_o = fetch_addr_q;
   assign hit           = |hit_way_i;

   // Any maintenance request stops new grants in the enabled states
   assign block_fetch = bypass_i | byp_pend_q | flush_i | flush_set_req_i;

   //////////////////////////////
   // State registers
   //////////////////////////////
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state_q     <= ST_DISABLED;
         flush_cnt_q <= '0;
         byp_pend_q  <= 1'b0;
      end
      else
      begin
         state_q     <= state_d;
         flush_cnt_q <= flush_cnt_d;
         byp_pend_q  <= byp_pend_d;
      end
   end

   always_ff @(posedge clk)
   begin
      if (fetch_gnt_o)
      begin
         fetch_addr_q <= fetch_addr_i;
      end
      if (save_victim)
      begin
         victim_q <= victim_way_i;   // Way to fill once the line arrives
      end
   end

   //////////////////////////////
   // Next state and outputs
   //////////////////////////////
   always_comb
   begin
      state_d         = state_q;
      flush_cnt_d     = flush_cnt_q;
      byp_pend_d      = byp_pend_q | bypass_i;   // Keep a bypass request seen mid-refill
      fetch_gnt_o     = 1'b0;
      fetch_rvalid_o  = 1'b0;
      flush_set_ack_o = 1'b0;
      bypassed_o      = 1'b0;
      flushed_o       = 1'b0;
      choose_o        = 1'b0;
      save_victim     = 1'b0;
      refill_req_o    = 1'b0;
      use_refill_o    = 1'b0;
      data_wr_way_o   = '0;
      tag_cmd_o       = '0;

      case (state_q)
         ST_DISABLED:
         begin
            bypassed_o      = 1'b1;
            flushed_o       = 1'b1;
            flush_set_ack_o = flush_set_req_i;   // Nothing cached to clear
            byp_pend_d      = 1'b0;
            flush_cnt_d     = '0;
            if (bypass_i)
            begin
               fetch_gnt_o = fetch_req_i;
               if (fetch_req_i)
               begin
                  state_d = ST_BYP_REFILL;
               end
            end
            else
            begin
               state_d = ST_FLUSH_ALL;
            end
         end

         ST_BYP_REFILL:
         begin
            bypassed_o      = 1'b1;
            flushed_o       = 1'b1;
            flush_set_ack_o = flush_set_req_i;
            byp_pend_d      = 1'b0;
            refill_req_o    = 1'b1;
            if (refill_gnt_i)
            begin
               state_d = ST_BYP_WAIT;
            end
         end

         ST_BYP_WAIT:
         begin
            bypassed_o      = 1'b1;
            flushed_o       = 1'b1;
            flush_set_ack_o = flush_set_req_i;
            byp_pend_d      = 1'b0;
            use_refill_o    = 1'b1;
            fetch_rvalid_o  = refill_rvalid_i;   // Single beat
            if (refill_rvalid_i)
            begin
               state_d = ST_DISABLED;
            end
         end

         // One set per cycle in all ways
         ST_FLUSH_ALL:
         begin
            tag_cmd_o = '{we: 1'b1, way_mask: '1, set: flush_cnt_q, entry: '0};
            if (flush_cnt_q == icache_pkg::FLUSH_LAST)
            begin
               flushed_o   = 1'b1;
               flush_cnt_d = '0;
               state_d     = ST_IDLE;
            end
            else
            begin
               flush_cnt_d = flush_cnt_q + 1'b1;
            end
         end

         ST_FLUSH_SET:
         begin
            tag_cmd_o = '{we: 1'b1, way_mask: '1, set: flush_set_addr_i.set, entry: '0};
            state_d   = ST_SET_ACK;
         end

         ST_SET_ACK:
         begin
            flush_set_ack_o = 1'b1;
            if (!flush_set_req_i)
            begin
               state_d = ST_IDLE;
            end
         end

         ST_IDLE:
         begin
            flush_cnt_d = '0;
            fetch_gnt_o = fetch_req_i & ~block_fetch;
            if (bypass_i | byp_pend_q)
            begin
               state_d = ST_DISABLED;
            end
            else if (flush_i)
            begin
               state_d = ST_FLUSH_ALL;
            end
            else if (flush_set_req_i)
            begin
               state_d = ST_FLUSH_SET;
            end
            else if (fetch_req_i)
            begin
               state_d = ST_LOOKUP;
            end
         end

         ST_LOOKUP:
         begin
            if (hit)
            begin
               fetch_rvalid_o = 1'b1;
               fetch_gnt_o    = fetch_req_i & ~block_fetch;   // Back-to-back hits
               if (!(fetch_req_i & ~block_fetch))
               begin
                  state_d = ST_IDLE;
               end
            end
            else
            begin
               save_victim  = 1'b1;
               choose_o     = all_valid_i;   // LFSR steps only on a full set
               refill_req_o = 1'b1;
               state_d      = refill_gnt_i ? ST_WAIT_DONE : ST_WAIT_GNT;
            end
         end

         ST_WAIT_GNT:
         begin
            refill_req_o = 1'b1;
            if (refill_gnt_i)
            begin
               state_d = ST_WAIT_DONE;
            end
         end

         // Line lands in the saved way as it is forwarded
         ST_WAIT_DONE:
         begin
            use_refill_o   = 1'b1;
            fetch_rvalid_o = refill_rvalid_i;
            data_wr_way_o  = victim_q & {icache_pkg::NB_WAYS{refill_rvalid_i}};
            tag_cmd_o      = '{we:       refill_rvalid_i,
                               way_mask: victim_q,
                               set:      fetch_addr_q.set,
                               entry:    '{valid: 1'b1, tag: fetch_addr_q.tag}};
            if (refill_rvalid_i)
            begin
               state_d = ST_IDLE;
            end
         end

         default:
         begin
            state_d = ST_DISABLED;
         end
      endcase
   end

endmodule

`default_nettype wire

// File: src/icache_top.sv
//////////////////////////////
// Instruction cache top level
// Controller, tag and data stores and victim choice
//////////////////////////////

`default_nettype none

module icache_top (
   input  wire                               clk,
   input  wire                               rst_n,
   input  wire                               bypass_i,
   output logic                              bypassed_o,
   input  wire                               flush_i,
   output logic                              flushed_o,
   input  wire                               flush_set_req_i,
   input  wire icache_pkg::fetch_addr_t      flush_set_addr_i,
   output logic                              flush_set_ack_o,
   input  wire                               fetch_req_i,
   input  wire icache_pkg::fetch_addr_t      fetch_addr_i,
   output logic                              fetch_gnt_o,
   output logic                              fetch_rvalid_o,
   output icache_pkg::word_t                 fetch_rdata_o,
   output logic                              refill_req_o,
   input  wire                               refill_gnt_i,
   output icache_pkg::fetch_addr_t           refill_addr_o,
   input  wire                               refill_rvalid_i,
   input  wire icache_pkg::line_t            refill_rdata_i
);

   icache_pkg::way_oh_t             hit_way;
   icache_pkg::way_oh_t             free_way;
   icache_pkg::way_oh_t             victim_way;
   icache_pkg::way_oh_t             data_wr_way;
   icache_pkg::tag_cmd_t            tag_cmd;
   logic [icache_pkg::SET_W-1:0]    data_rd_set;
   logic [1:0]                      word_sel;
   logic                            all_valid;
   logic                            choose;
   logic                            use_refill;

   icache_ctrl_fsm i_ctrl_fsm (
      .clk              (clk),
      .rst_n            (rst_n),
      .bypass_i         (bypass_i),
      .flush_i          (flush_i),
      .flush_set_req_i  (flush_set_req_i),
      .flush_set_addr_i (flush_set_addr_i),
      .flush_set_ack_o  (flush_set_ack_o),
      .bypassed_o       (bypassed_o),
      .flushed_o        (flushed_o),
      .fetch_req_i      (fetch_req_i),
      .fetch_addr_i     (fetch_addr_i),
      .fetch_gnt_o      (fetch_gnt_o),
      .fetch_rvalid_o   (fetch_rvalid_o),
      .hit_way_i        (hit_way),
      .all_valid_i      (all_valid),
      .victim_way_i     (victim_way),
      .choose_o         (choose),
      .tag_cmd_o        (tag_cmd),
      .data_rd_set_o    (data_rd_set),
      .data_wr_way_o    (data_wr_way),
      .word_sel_o       (word_sel),
      .use_refill_o     (use_refill),
      .refill_req_o     (refill_req_o),
      .refill_gnt_i     (refill_gnt_i),
      .refill_addr_o    (refill_addr_o),
      .refill_rvalid_i  (refill_rvalid_i)
   );

   // Tags are read on every grant, compared against the held address
   icache_tag_store i_tag_store (
      .clk         (clk),
      .rst_n       (rst_n),
      .tag_cmd_i   (tag_cmd),
      .rd_en_i     (fetch_gnt_o),
      .rd_set_i    (data_rd_set),
      .cmp_tag_i   (refill_addr_o.tag),
      .hit_way_o   (hit_way),
      .all_valid_o (all_valid),
      .free_way_o  (free_way)
   );

   icache_data_store i_data_store (
      .clk           (clk),
      .wr_way_i      (data_wr_way),
      .wr_set_i      (tag_cmd.set),
      .wr_line_i     (refill_rdata_i),
      .rd_set_i      (data_rd_set),
      .hit_way_i     (hit_way),
      .word_sel_i    (word_sel),
      .use_refill_i  (use_refill),
      .refill_line_i (refill_rdata_i),
      .rdata_o       (fetch_rdata_o)
   );

   icache_victim_select i_victim_select (
      .clk          (clk),
      .rst_n        (rst_n),
      .choose_i     (choose),
      .all_valid_i  (all_valid),
      .free_way_i   (free_way),
      .victim_way_o (victim_way)
   );

endmodule

`default_nettype wire

// File: verif/icache_refill_mem.sv
//////////////////////////////
// Next-level memory model on the refill port
// Grants after a random delay, returns one line beat, counts refills
//////////////////////////////

`default_nettype none

module icache_refill_mem (
   input  wire                          clk,
   input  wire                          rst_n,
   input  wire                          req_i,
   input  wire icache_pkg::fetch_addr_t addr_i,
   output logic                         gnt_o,
   output logic                         rvalid_o,
   output icache_pkg::line_t            rdata_o,
   output int                           count_o
);

   localparam logic [31:0] DATA_KEY = 32'hA5A5_0000;
   localparam logic [31:0] SEED     = 32'd55756;

   logic [31:0]             rng_q     = SEED;
   logic [31:0]             rng_next;
   logic [1:0]              delay_q   = 2'd0;
   logic                    gnt_q     = 1'b0;
   logic                    rvalid_q  = 1'b0;
   logic                    beat_pend = 1'b0;
   icache_pkg::line_t       line_q    = '0;
   icache_pkg::fetch_addr_t beat_addr = '0;
   int                      count_q   = 0;

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Word i of a line carries its own word address XOR the key
   function automatic icache_pkg::line_t build_line(input icache_pkg::fetch_addr_t a);
      icache_pkg::line_t l;
      for (int i = 0; i < 4; i++)
      begin
         l[i*32 +: 32] = {2'b00, a.tag, a.set, 2'(i)} ^ DATA_KEY;
      end
      return l;
   endfunction

   assign rng_next = xorshift(rng_q);
   assign gnt_o    = gnt_q;
   assign rvalid_o = rvalid_q;
   assign rdata_o  = line_q;
   assign count_o  = count_q;

   always @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         gnt_q     <= 1'b0;
         rvalid_q  <= 1'b0;
         beat_pend <= 1'b0;
         delay_q   <= 2'd0;
         count_q   <= 0;
         rng_q     <= SEED;
      end
      else
      begin
         gnt_q    <= 1'b0;
         rvalid_q <= 1'b0;
         if (beat_pend)
         begin
            rvalid_q  <= 1'b1;
            line_q    <= build_line(beat_addr);
            beat_pend <= 1'b0;
         end
         if (gnt_q)
         begin
            beat_pend <= 1'b1;   // Beat follows one cycle after the grant
            beat_addr <= addr_i;
            count_q   <= count_q + 1;
         end
         else if (req_i && !beat_pend && !rvalid_q)
         begin
            if (delay_q == 2'd0)
            begin
               gnt_q   <= 1'b1;
               rng_q   <= rng_next;
               delay_q <= rng_next[1:0];   // Wait before the next grant
            end
            else
            begin
               delay_q <= delay_q - 2'd1;
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: verif/icache_asserts.sv
//////////////////////////////
// Handshake assertions of the instruction cache
// Bound to the top level at the end of this file
//////////////////////////////

`default_nettype none

module icache_asserts (
   input wire                          clk,
   input wire                          rst_n,
   input wire                          fetch_req_i,
   input wire icache_pkg::fetch_addr_t fetch_addr_i,
   input wire                          fetch_gnt_o,
   input wire                          fetch_rvalid_o,
   input wire                          refill_req_o,
   input wire icache_pkg::fetch_addr_t refill_addr_o,
   input wire                          refill_gnt_i,
   input wire                          flush_set_req_i,
   input wire                          flush_set_ack_o
);

   int pending_q;      // Grants still waiting for their rvalid
   int fail_cnt = 0;   // Failed assertions so far

   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         pending_q <= 0;
      end
      else
      begin
         pending_q <= pending_q + int'(fetch_gnt_o) - int'(fetch_rvalid_o);
      end
   end

   fetch_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_req_i && !fetch_gnt_o |=> fetch_req_i && $stable(fetch_addr_i))
   else
   begin
      $error("fetch request dropped or changed before its grant");
      fail_cnt++;
   end

   refill_req_held: assert property (@(posedge clk) disable iff (!rst_n)
      refill_req_o && !refill_gnt_i |=> refill_req_o && $stable(refill_addr_o))
   else
   begin
      $error("refill request dropped or changed before its grant");
      fail_cnt++;
   end

   // Four-phase set flush
   set_ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(flush_set_ack_o) |-> flush_set_req_i)
   else
   begin
      $error("set flush acknowledge rose without a request");
      fail_cnt++;
   end

   rvalid_has_grant: assert property (@(posedge clk) disable iff (!rst_n)
      fetch_rvalid_o |-> pending_q > 0)
   else
   begin
      $error("fetch rvalid without an outstanding grant");
      fail_cnt++;
   end

endmodule

bind icache_top icache_asserts i_asserts (.*);

`default_nettype wire

// File: verif/icache_tb.sv
//////////////////////////////
// Testbench of the instruction cache
// Directed tests of reset flush, lookup, refill, set flush and bypass
//////////////////////////////

`default_nettype none

module icache_tb;

   localparam int          TIMEOUT_CYCLES = 4000;   // Well above the longest directed sequence
   localparam logic [31:0] DATA_KEY       = 32'hA5A5_0000;

   logic                      clk;
   logic                      rst_n;
   logic                      bypass_i;
   logic                      flush_i;
   logic                      flush_set_req_i;
   icache_pkg::fetch_addr_t   flush_set_addr_i;
   logic                      fetch_req_i;
   icache_pkg::fetch_addr_t   fetch_addr_i;
   logic                      bypassed_o;
   logic                      flushed_o;
   logic                      flush_set_ack_o;
   logic                      fetch_gnt_o;
   logic                      fetch_rvalid_o;
   icache_pkg::word_t         fetch_rdata_o;
   logic                      refill_req_o;
   logic                      refill_gnt_i;
   icache_pkg::fetch_addr_t   refill_addr_o;
   logic                      refill_rvalid_i;
   icache_pkg::line_t         refill_rdata_i;
   int                        refill_count;
   int                        n_checks;
   int                        n_errors;
   int                        cycle_cnt;
   icache_pkg::fetch_addr_t   addr_a;
   icache_pkg::fetch_addr_t   addr_b;

   icache_top i_dut (.*);

   icache_refill_mem i_refill_mem (
      .clk      (clk),
      .rst_n    (rst_n),
      .req_i    (refill_req_o),
      .addr_i   (refill_addr_o),
      .gnt_o    (refill_gnt_i),
      .rvalid_o (refill_rvalid_i),
      .rdata_o  (refill_rdata_i),
      .count_o  (refill_count)
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   initial
   begin
      cycle_cnt = 0;
      while (cycle_cnt < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_cnt++;
      end
      $display("Timeout after %0d cycles, the DUT stopped answering", TIMEOUT_CYCLES);
      $display("=== FAIL ===");
      $finish;
   end

   //////////////////////////////
   // Expected values and compare tasks
   //////////////////////////////

   // Each memory word holds its word address (byte address / 4) XOR a fixed key
   function automatic icache_pkg::word_t expected_word(input icache_pkg::fetch_addr_t a);
      return {2'b00, a[31:2]} ^ DATA_KEY;
   endfunction

   function automatic icache_pkg::fetch_addr_t make_addr(input logic [23:0] t,
                                                         input logic [3:0]  s,
                                                         input logic [1:0]  w);
      return '{tag: t, set: s, word: w, byte_off: 2'b00};
   endfunction

   task automatic check_word(input string name,
                             input icache_pkg::word_t got,
                             input icache_pkg::word_t exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("Fail at %0t: %s = %h, expected %h", $time, name, got, exp);
      end
   endtask

   task automatic check_count(input string name, input int got, input int exp);
      n_checks++;
      if (got != exp)
      begin
         n_errors++;
         $display("Fail at %0t: %s = %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      n_checks++;
      if (got !== exp)
      begin
         n_errors++;
         $display("Fail at %0t: %s = %b, expected %b", $time, name, got, exp);
      end
   endtask

   //////////////////////////////
   // Fetch and flush helpers
   //////////////////////////////
   task automatic start_fetch(input icache_pkg::fetch_addr_t a);
      fetch_req_i  <= 1'b1;
      fetch_addr_i <= a;
   endtask

   // Waits for grant and rvalid, then checks data and refill traffic
   task automatic complete_fetch(input icache_pkg::fetch_addr_t a, input int exp_refills);
      int refills_before;
      int latency;
      refills_before = refill_count;
      do @(posedge clk); while (!fetch_gnt_o);
      fetch_req_i <= 1'b0;
      latency = 0;
      do
      begin
         @(posedge clk);
         latency++;
      end
      while (!fetch_rvalid_o);
      check_word("fetch_rdata_o", fetch_rdata_o, expected_word(a));
      check_count("refills for this fetch", refill_count - refills_before, exp_refills);
      if (exp_refills == 0)
      begin
         check_count("hit latency", latency, 1);   // rvalid right after the grant
      end
   endtask

   task automatic fetch_and_check(input icache_pkg::fetch_addr_t a, input int exp_refills);
      start_fetch(a);
      complete_fetch(a, exp_refills);
   endtask

   // Entered right after the edge that starts the sweep
   task automatic run_flush_sweep();
      int n;
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
         check_flag("fetch_gnt_o", fetch_gnt_o, 1'b0);
      end
      while (!flushed_o);
      check_count("flush sweep cycles", n, icache_pkg::NB_SETS);
   endtask

   //////////////////////////////
   // Directed tests
   //////////////////////////////
   task automatic reset_then_miss_hit();
      repeat (5) @(posedge clk);
      check_flag("bypassed_o", bypassed_o, 1'b1);
      check_flag("flushed_o", flushed_o, 1'b1);
      check_flag("fetch_gnt_o", fetch_gnt_o, 1'b0);
      check_flag("fetch_rvalid_o", fetch_rvalid_o, 1'b0);
      check_flag("refill_req_o", refill_req_o, 1'b0);
      check_flag("flush_set_ack_o", flush_set_ack_o, 1'b0);
      rst_n <= 1'b1;
      @(posedge clk);   // Disabled state, flush starts next
      check_flag("flushed_o", flushed_o, 1'b1);
      run_flush_sweep();
      fetch_and_check(addr_a, 1);
      fetch_and_check(addr_a, 0);
      fetch_and_check(make_addr(addr_a.tag, addr_a.set, 2'd3), 0);   // Other word, same line
   endtask

   task automatic set_flush_refetch();
      fetch_and_check(addr_b, 1);
      flush_set_req_i  <= 1'b1;
      flush_set_addr_i <= addr_a;
      do @(posedge clk); while (!flush_set_ack_o);
      flush_set_req_i <= 1'b0;
      do @(posedge clk); while (flush_set_ack_o);
      fetch_and_check(addr_a, 1);   // Set 2 was cleared
      fetch_and_check(addr_b, 0);
   endtask

   task automatic full_flush_refetch();
      flush_i <= 1'b1;
      start_fetch(addr_a);          // Request stays pending over the sweep
      @(posedge clk);
      flush_i <= 1'b0;
      run_flush_sweep();
      complete_fetch(addr_a, 1);
      fetch_and_check(addr_b, 1);
      fetch_and_check(addr_a, 0);
   endtask

   // One more tag than ways in a single set
   task automatic thrash_one_set();
      logic [23:0] t;
      for (int i = 0; i < 5; i++)
      begin
         t = 24'h000400 + 24'(i);
         fetch_and_check(make_addr(t, 4'h9, 2'(i)), 1);
      end
      fetch_and_check(make_addr(24'h000404, 4'h9, 2'd2), 0);
   endtask

   task automatic bypass_fetches();
      bypass_i <= 1'b1;
      repeat (2) @(posedge clk);
      check_flag("bypassed_o", bypassed_o, 1'b1);
      fetch_and_check(addr_a, 1);
      fetch_and_check(addr_a, 1);
      fetch_and_check(addr_b, 1);
      bypass_i <= 1'b0;
      @(posedge clk);
      run_flush_sweep();
      fetch_and_check(addr_a, 1);
      check_flag("bypassed_o", bypassed_o, 1'b0);
   endtask

   initial
   begin
      rst_n            = 1'b0;
      bypass_i         = 1'b0;
      flush_i          = 1'b0;
      flush_set_req_i  = 1'b0;
      flush_set_addr_i = '0;
      fetch_req_i      = 1'b0;
      fetch_addr_i     = '0;
      n_checks         = 0;
      n_errors         = 0;
      addr_a           = make_addr(24'h000123, 4'h2, 2'd1);
      addr_b           = make_addr(24'h00ABCD, 4'h5, 2'd3);

      reset_then_miss_hit();
      set_flush_refetch();
      full_flush_refetch();
      thrash_one_set();
      bypass_fetches();
      repeat (2) @(posedge clk);

      $display("Checks: %0d, errors: %0d, assertion failures: %0d",
               n_checks, n_errors, i_dut.i_asserts.fail_cnt);
      if (n_errors == 0 && i_dut.i_asserts.fail_cnt == 0)
      begin
         $display("=== PASS ===");
      end
      else
      begin
         $display("=== FAIL ===");
      end
      $finish;
   end

endmodule

`default_nettype wire

// File: all.f
src/icache_pkg.sv
src/icache_victim_select.sv
src/icache_tag_store.sv
src/icache_data_store.sv
src/icache_ctrl_fsm.sv
src/icache_top.sv
verif/icache_refill_mem.sv
verif/icache_asserts.sv
verif/icache_tb.sv

// File: Bender.yml
package:
  name: icache

sources:
  - src/icache_pkg.sv
  - src/icache_victim_select.sv
  - src/icache_tag_store.sv
  - src/icache_data_store.sv
  - src/icache_ctrl_fsm.sv
  - src/icache_top.sv
  - target: test
    files:
      - verif/icache_refill_mem.sv
      - verif/icache_asserts.sv
      - verif/icache_tb.sv
